// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_mpa_mips_32
RTL_TOP    ?= mpa_mips_32
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST) source/mpa_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/mpa_alu.sv
// MPA ALU with operand B selection, add, subtract and bitwise logic
`default_nettype none
`timescale 1ns/10ps

module mpa_alu (
    input  mpa_pkg::alu_op_e    alu_op,
    input  mpa_pkg::operand_b_e operand_b,
    input  mpa_pkg::data_t      rs_val,
    input  mpa_pkg::data_t      rt_val,
    input  logic [15:0]         imm,
    output mpa_pkg::data_t      result
);
    import mpa_pkg::*;

    data_t opb;     // Second operand after selection

    // Operand B mux
    always_comb begin
        case (operand_b)
            OPB_SIMM: opb = data_t'({{16{imm[15]}}, imm});  // Offsets, ADDIU
            OPB_ZIMM: opb = data_t'({16'h0000, imm});       // ANDI/ORI/XORI
            default:  opb = rt_val;
        endcase
    end

    // Wrapping arithmetic, carry and borrow dropped
    always_comb begin
        case (alu_op)
            ALU_SUB: result = rs_val - opb;
            ALU_AND: result = rs_val & opb;
            ALU_OR:  result = rs_val | opb;
            ALU_XOR: result = rs_val ^ opb;
            ALU_NOR: result = ~(rs_val | opb);
            default: result = rs_val + opb;     // ADD, also address calc
        endcase
    end

endmodule

`default_nettype wire

// File: source/mpa_decoder.sv
// MPA instruction decoder, opcode and funct to datapath control selections
`default_nettype none
`timescale 1ns/10ps

module mpa_decoder (
    input  mpa_pkg::instr_t     instr,
    output logic                rf_we,
    output logic                dm_we,
    output mpa_pkg::alu_op_e    alu_op,
    output mpa_pkg::operand_b_e operand_b,
    output mpa_pkg::wb_sel_e    wb_sel,
    output mpa_pkg::store_e     store_kind,
    output logic                dest_is_rt
);
    import mpa_pkg::*;

    // MIPS I primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b00_0000;    // R-type, look at funct
    localparam logic [5:0] OP_ADDIU   = 6'b00_1001;
    localparam logic [5:0] OP_ANDI    = 6'b00_1100;
    localparam logic [5:0] OP_ORI     = 6'b00_1101;
    localparam logic [5:0] OP_XORI    = 6'b00_1110;
    localparam logic [5:0] OP_LUI     = 6'b00_1111;
    localparam logic [5:0] OP_LB      = 6'b10_0000;
    localparam logic [5:0] OP_LH      = 6'b10_0001;
    localparam logic [5:0] OP_LW      = 6'b10_0011;
    localparam logic [5:0] OP_LBU     = 6'b10_0100;
    localparam logic [5:0] OP_LHU     = 6'b10_0101;
    localparam logic [5:0] OP_SB      = 6'b10_1000;
    localparam logic [5:0] OP_SH      = 6'b10_1001;
    localparam logic [5:0] OP_SW      = 6'b10_1011;

    // SPECIAL funct codes
    localparam logic [5:0] FN_ADD  = 6'b10_0000;   // No overflow trap here
    localparam logic [5:0] FN_ADDU = 6'b10_0001;
    localparam logic [5:0] FN_SUB  = 6'b10_0010;   // No overflow trap here
    localparam logic [5:0] FN_SUBU = 6'b10_0011;
    localparam logic [5:0] FN_AND  = 6'b10_0100;
    localparam logic [5:0] FN_OR   = 6'b10_0101;
    localparam logic [5:0] FN_XOR  = 6'b10_0110;
    localparam logic [5:0] FN_NOR  = 6'b10_0111;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Defaults, anything not listed is a no-op
        rf_we      = 1'b0;
        dm_we      = 1'b0;
        alu_op     = ALU_ADD;
        operand_b  = OPB_RT;
        wb_sel     = WB_ALU;
        store_kind = ST_NONE;
        dest_is_rt = 1'b0;

        unique case (opcode)
            OP_SPECIAL: begin
                // rd destination, rt operand
                rf_we = 1'b1;
                case (funct)
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    default:         rf_we  = 1'b0;  // SLT, shifts, JR etc.
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI: begin
                rf_we      = 1'b1;
                dest_is_rt = 1'b1;
                operand_b  = (opcode == OP_ADDIU) ? OPB_SIMM : OPB_ZIMM;
                case (opcode)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_LUI: begin
                rf_we      = 1'b1;
                dest_is_rt = 1'b1;
                wb_sel     = WB_LUI;    // ALU result ignored
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                // Address is rs + sign-extended offset
                rf_we      = 1'b1;
                dest_is_rt = 1'b1;
                operand_b  = OPB_SIMM;
                case (opcode)
                    OP_LB:   wb_sel = WB_LB;
                    OP_LBU:  wb_sel = WB_LBU;
                    OP_LH:   wb_sel = WB_LH;
                    OP_LHU:  wb_sel = WB_LHU;
                    default: wb_sel = WB_LW;
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                dm_we     = 1'b1;
                operand_b = OPB_SIMM;
                case (opcode)
                    OP_SB:   store_kind = ST_BYTE;
                    OP_SH:   store_kind = ST_HALF;
                    default: store_kind = ST_WORD;
                endcase
            end
            default: ;  // Branches, jumps, SLTI etc. write nothing
        endcase
    end

endmodule

`default_nettype wire

// File: source/mpa_defs.svh
// MPA core widths, memory depths, reset PC and debug target codes
`ifndef MPA_DEFS_SVH
`define MPA_DEFS_SVH

// Datapath widths
`define MPA_DATA_W      32  // Data and instruction word
`define MPA_ADDR_W      32  // Byte address
`define MPA_REG_ADDR_W  5   // Register index, 32 GPRs

// Memory depths in words, kept to powers of two
`define MPA_IM_DEPTH    32
`define MPA_DM_DEPTH    32

// PC value after reset and while the back door is open
`define MPA_RESET_PC    32'h0000_0000

// debug_func codes
// Code 0 selects nothing and reads back zero
`define MPA_DBG_IM      2'd1    // Instruction memory
`define MPA_DBG_DM      2'd2    // Data memory
`define MPA_DBG_MR      2'd3    // Register file

`endif

// File: source/mpa_load_store.sv
// MPA load/store unit, store merging and load extension for write-back
`default_nettype none
`timescale 1ns/10ps

module mpa_load_store (
    input  mpa_pkg::wb_sel_e wb_sel,
    input  mpa_pkg::store_e  store_kind,
    input  mpa_pkg::data_t   alu_result,
    input  mpa_pkg::data_t   rt_val,
    input  mpa_pkg::data_t   mem_rdata,
    input  logic [15:0]      imm,
    output mpa_pkg::data_t   mem_wdata,
    output mpa_pkg::data_t   rf_wdata
);
    import mpa_pkg::*;

    // Sub-word views of the addressed word
    // Always the low lanes, byte offset in the address is ignored
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign ld_byte = mem_rdata[7:0];
    assign ld_half = mem_rdata[15:0];

    // Store merge, read-modify-write of the old word
    always_comb begin
        case (store_kind)
            ST_BYTE: mem_wdata = {mem_rdata[31:8], rt_val[7:0]};
            ST_HALF: mem_wdata = {mem_rdata[31:16], rt_val[15:0]};
            default: mem_wdata = rt_val;    // SW, dm_we low otherwise
        endcase
    end

    // Register write-back select
    always_comb begin
        case (wb_sel)
            WB_LB:  rf_wdata = {{24{ld_byte[7]}}, ld_byte};     // Sign-extend
            WB_LBU: rf_wdata = {24'h00_0000, ld_byte};
            WB_LH:  rf_wdata = {{16{ld_half[15]}}, ld_half};
            WB_LHU: rf_wdata = {16'h0000, ld_half};
            WB_LW:  rf_wdata = mem_rdata;
            WB_LUI: rf_wdata = {imm, 16'h0000};                 // Upper half
            default: begin
                rf_wdata = alu_result;  // R-type and I-type ALU ops
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/mpa_mips_32.sv
// MPA single-cycle 32-bit MIPS subset core with debug back door
`default_nettype none
`timescale 1ns/10ps

`include "mpa_defs.svh"

module mpa_mips_32 (
    input  logic               mem_debug_clk_gate,
    input  logic               HW_RSTn,
    input  logic               mem_debug,   // Back door open, PC held
    input  mpa_pkg::dbg_func_t debug_func,  // 1 IM, 2 DM, 3 registers
    input  logic               debug_we,
    input  mpa_pkg::addr_t     addr,
    input  mpa_pkg::data_t     din,
    output mpa_pkg::data_t     dout
);
    import mpa_pkg::*;

    addr_t      pc_q;
    instr_t     instr;
    reg_addr_t  rs, rt, rd;

    // Decoder outputs
    logic       dec_rf_we, dec_dm_we, dest_is_rt;
    alu_op_e    alu_op;
    operand_b_e operand_b;
    wb_sel_e    wb_sel;
    store_e     store_kind;

    // Datapath
    data_t      rs_val, rt_val, alu_result;
    data_t      dm_rdata, mem_wdata, rf_wdata;

    // Back door or run-mode selections
    addr_t      im_addr, dm_addr;
    reg_addr_t  rf_ra1, rf_wa;
    data_t      rf_wd, dm_wd;
    logic       im_we, dm_we, rf_we;

    // Instruction fields
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    // PC, parked at the reset vector while debugging
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc_q <= `MPA_RESET_PC;
        end else if (mem_debug) begin
            pc_q <= `MPA_RESET_PC;
        end else begin
            pc_q <= pc_q + addr_t'(4);  // No branches
        end
    end

    // Address and data muxes
    assign im_addr = mem_debug ? addr : pc_q;
    assign dm_addr = mem_debug ? addr : alu_result;    // ALU gives load/store addr
    assign rf_ra1  = mem_debug ? addr[4:0] : rt;
    assign rf_wa   = mem_debug ? addr[4:0] : (dest_is_rt ? rt : rd);
    assign rf_wd   = mem_debug ? din : rf_wdata;
    assign dm_wd   = mem_debug ? din : mem_wdata;

    // Write enables, run-mode strobes masked in debug
    assign im_we = mem_debug && debug_we && (debug_func == `MPA_DBG_IM);
    assign dm_we = mem_debug ? (debug_we && (debug_func == `MPA_DBG_DM)) : dec_dm_we;
    assign rf_we = mem_debug ? (debug_we && (debug_func == `MPA_DBG_MR)) : dec_rf_we;

    // Back door read, port 1 of the register file doubles as debug port
    always_comb begin
        case (debug_func)
            `MPA_DBG_IM: dout = instr;
            `MPA_DBG_DM: dout = dm_rdata;
            `MPA_DBG_MR: dout = rt_val;
            default:     dout = '0;
        endcase
    end

    mpa_word_mem #(.DEPTH(`MPA_IM_DEPTH)) instr_mem_i (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .addr               (im_addr),
        .wdata              (din),
        .we                 (im_we),
        .rdata              (instr)
    );

    mpa_decoder decoder_i (
        .instr      (instr),
        .rf_we      (dec_rf_we),
        .dm_we      (dec_dm_we),
        .alu_op     (alu_op),
        .operand_b  (operand_b),
        .wb_sel     (wb_sel),
        .store_kind (store_kind),
        .dest_is_rt (dest_is_rt)
    );

    mpa_reg_file reg_file_i (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .ra0                (rs),
        .ra1                (rf_ra1),
        .wa                 (rf_wa),
        .wd                 (rf_wd),
        .we                 (rf_we),
        .rd0                (rs_val),
        .rd1                (rt_val)
    );

    mpa_alu alu_i (
        .alu_op    (alu_op),
        .operand_b (operand_b),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .imm       (instr[15:0]),
        .result    (alu_result)
    );

    mpa_word_mem #(.DEPTH(`MPA_DM_DEPTH)) data_mem_i (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .addr               (dm_addr),
        .wdata              (dm_wd),
        .we                 (dm_we),
        .rdata              (dm_rdata)
    );

    mpa_load_store load_store_i (
        .wb_sel     (wb_sel),
        .store_kind (store_kind),
        .alu_result (alu_result),
        .rt_val     (rt_val),
        .mem_rdata  (dm_rdata),
        .imm        (instr[15:0]),
        .mem_wdata  (mem_wdata),
        .rf_wdata   (rf_wdata)
    );

endmodule

`default_nettype wire

// File: source/mpa_pkg.sv
// MPA core shared vector types and control encodings
`default_nettype none

`include "mpa_defs.svh"

package mpa_pkg;

    // Plain vectors for the widths that carry a meaning
    typedef logic [`MPA_DATA_W-1:0]     data_t;     // Register or memory word
    typedef logic [`MPA_DATA_W-1:0]     instr_t;    // Fetched instruction
    typedef logic [`MPA_ADDR_W-1:0]     addr_t;     // Byte address
    typedef logic [`MPA_REG_ADDR_W-1:0] reg_addr_t; // GPR index
    typedef logic [1:0]                 dbg_func_t; // Back door target

    // ALU operation
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5
    } alu_op_e;

    // ALU second operand source
    typedef enum logic [1:0] {
        OPB_RT   = 2'd0,    // Register rt
        OPB_SIMM = 2'd1,    // Sign-extended imm
        OPB_ZIMM = 2'd2     // Zero-extended imm
    } operand_b_e;

    // Register write-back source
    typedef enum logic [2:0] {
        WB_ALU = 3'd0,
        WB_LB  = 3'd1,
        WB_LBU = 3'd2,
        WB_LH  = 3'd3,
        WB_LHU = 3'd4,
        WB_LW  = 3'd5,
        WB_LUI = 3'd6
    } wb_sel_e;

    // Store width
    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_BYTE = 2'd1,
        ST_HALF = 2'd2,
        ST_WORD = 2'd3
    } store_e;

endpackage

`default_nettype wire

// File: source/mpa_reg_file.sv
// MPA general purpose register file, 32 entries, 2 read ports, 1 write port
`default_nettype none
`timescale 1ns/10ps

module mpa_reg_file (
    input  logic               mem_debug_clk_gate,
    input  logic               HW_RSTn,
    input  mpa_pkg::reg_addr_t ra0,
    input  mpa_pkg::reg_addr_t ra1,
    input  mpa_pkg::reg_addr_t wa,
    input  mpa_pkg::data_t     wd,
    input  logic               we,
    output mpa_pkg::data_t     rd0,
    output mpa_pkg::data_t     rd1
);
    import mpa_pkg::*;

    localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

    data_t regs [NUM_REGS];

    // All registers cleared on reset
    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin   // $zero is never written
            regs[wa] <= wd;
        end
    end

    // Combinational reads, $zero forced
    assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

`default_nettype wire

// File: source/mpa_word_mem.sv
// MPA word memory, combinational read and rising-edge write
`default_nettype none
`timescale 1ns/10ps

module mpa_word_mem #(
    parameter int DEPTH = 32    // Words, power of two
) (
    input  logic           mem_debug_clk_gate,
    input  mpa_pkg::addr_t addr,
    input  mpa_pkg::data_t wdata,
    input  logic           we,
    output mpa_pkg::data_t rdata
);
    import mpa_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    data_t               mem [DEPTH];
    logic  [IDX_W-1:0]   word_idx;

    // Byte address to word index
    // Bits 1:0 dropped, upper bits wrap modulo DEPTH
    assign word_idx = addr[IDX_W+1:2];

    always_ff @(posedge mem_debug_clk_gate) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];   // Async read

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/mpa_pkg.sv
source/mpa_decoder.sv
source/mpa_alu.sv
source/mpa_reg_file.sv
source/mpa_word_mem.sv
source/mpa_load_store.sv
source/mpa_mips_32.sv
testbench/tb_mpa_mips_32.sv

// File: testbench/tb_mpa_mips_32.sv
// MPA core testbench, directed tests driven through the debug back door
`default_nettype none
`timescale 1ns/10ps

`include "mpa_defs.svh"

module tb_mpa_mips_32;
    import mpa_pkg::*;

    // Cycle budget, roughly twice the summed test lengths
    localparam int LOAD_CYCLES = 2 * `MPA_IM_DEPTH + 16;    // IM clear plus program
    localparam int TEST_CYCLES = 8 + 150 + 4 * (LOAD_CYCLES + 30)
                               + (LOAD_CYCLES + 4 * 32 + 10) + (LOAD_CYCLES + 45);
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic      mem_debug_clk_gate = 1'b0;
    logic      hw_rstn;
    logic      mem_debug;
    dbg_func_t debug_func;
    logic      debug_we;
    addr_t     addr;
    data_t     din;
    data_t     dout;

    int        cycle_cnt = 0;
    int        err_cnt;
    int        test_cnt;
    int        err_at_start;    // err_cnt when the current test began
    instr_t    prog [$];        // Program for the next run, from address 0

    mpa_mips_32 dut_i (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (hw_rstn),
        .mem_debug          (mem_debug),
        .debug_func         (debug_func),
        .debug_we           (debug_we),
        .addr               (addr),
        .din                (din),
        .dout               (dout)
    );

    always #4 mem_debug_clk_gate = ~mem_debug_clk_gate;    // 8 ns period

    // Watchdog
    always @(posedge mem_debug_clk_gate) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // MIPS I field packing
    function automatic instr_t encode_r(input int rs, input int rt, input int rd,
                                        input logic [5:0] funct);
        return {6'b00_0000, 5'(rs), 5'(rt), 5'(rd), 5'b0_0000, funct};
    endfunction

    function automatic instr_t encode_i(input logic [5:0] op, input int rs, input int rt,
                                        input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic check_word(input data_t got, input data_t exp, input string what);
        assert (got === exp) else begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // One back door write, strobe high for a single edge
    task automatic debug_write(input dbg_func_t func, input addr_t a, input data_t d);
        @(posedge mem_debug_clk_gate);
        mem_debug  <= 1'b1;
        debug_func <= func;
        addr       <= a;
        din        <= d;
        debug_we   <= 1'b1;
        @(posedge mem_debug_clk_gate);
        debug_we   <= 1'b0;
    endtask

    // dout is combinational, sampled mid-cycle
    task automatic debug_read(input dbg_func_t func, input addr_t a, output data_t d);
        @(posedge mem_debug_clk_gate);
        mem_debug  <= 1'b1;
        debug_func <= func;
        addr       <= a;
        debug_we   <= 1'b0;
        @(negedge mem_debug_clk_gate);
        d = dout;
    endtask

    // Zero words decode as SLL, unsupported, so the rest of IM is a no-op
    task automatic load_program();
        for (int i = 0; i < `MPA_IM_DEPTH; i++) begin
            debug_write(`MPA_DBG_IM, addr_t'(4 * i), '0);
        end
        foreach (prog[i]) begin
            debug_write(`MPA_DBG_IM, addr_t'(4 * i), prog[i]);
        end
    endtask

    // One instruction per edge while mem_debug is low
    task automatic run_cycles(input int n);
        @(posedge mem_debug_clk_gate);
        mem_debug <= 1'b0;
        repeat (n) @(posedge mem_debug_clk_gate);
        mem_debug <= 1'b1;
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        if (err_cnt == err_at_start) begin
            $display("%-20s ok", name);
        end else begin
            $display("%-20s %0d check(s) failed", name, err_cnt - err_at_start);
        end
        err_at_start = err_cnt;
    endtask

    task automatic check_back_door();
        data_t im_val [8];
        data_t dm_val [8];
        data_t rf_val [32];
        data_t got;
        for (int i = 0; i < 8; i++) begin
            im_val[i] = $urandom();
            dm_val[i] = $urandom();
            debug_write(`MPA_DBG_IM, addr_t'(16 * i), im_val[i]);  // Words 0, 4 .. 28
            debug_write(`MPA_DBG_DM, addr_t'(16 * i), dm_val[i]);
        end
        for (int r = 0; r < 32; r++) begin
            rf_val[r] = $urandom();
            debug_write(`MPA_DBG_MR, addr_t'(r), rf_val[r]);
        end
        rf_val[0] = '0;     // $zero ignores the write
        for (int i = 0; i < 8; i++) begin
            debug_read(`MPA_DBG_IM, addr_t'(16 * i), got);
            check_word(got, im_val[i], $sformatf("IM word %0d", 4 * i));
            debug_read(`MPA_DBG_DM, addr_t'(16 * i), got);
            check_word(got, dm_val[i], $sformatf("DM word %0d", 4 * i));
        end
        for (int r = 0; r < 32; r++) begin
            debug_read(`MPA_DBG_MR, addr_t'(r), got);
            check_word(got, rf_val[r], $sformatf("register r%0d", r));
        end
        debug_read(2'd0, addr_t'(0), got);     // No target, IM word 0 is nonzero here
        check_word(got, '0, "debug_func 0 reads zero");
        report_test("back door");
    endtask

    task automatic run_r_type_ops();
        logic [5:0] functs [8];
        data_t      exp_v [8];
        data_t      a;
        data_t      b;
        data_t      got;
        a = $urandom();
        b = $urandom();
        functs = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27};
        exp_v  = '{a + b, a + b, a - b, a - b, a & b, a | b, a ^ b, ~(a | b)};
        debug_write(`MPA_DBG_MR, addr_t'(1), a);
        debug_write(`MPA_DBG_MR, addr_t'(2), b);
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back(encode_r(1, 2, 10 + i, functs[i]));  // rd = r10 .. r17
        end
        load_program();
        run_cycles(prog.size());
        for (int i = 0; i < 8; i++) begin
            debug_read(`MPA_DBG_MR, addr_t'(10 + i), got);
            check_word(got, exp_v[i], $sformatf("funct %h into r%0d", functs[i], 10 + i));
        end
        debug_read(`MPA_DBG_MR, addr_t'(1), got);
        check_word(got, a, "rs r1 unchanged");
        debug_read(`MPA_DBG_MR, addr_t'(2), got);
        check_word(got, b, "rt r2 unchanged");
        report_test("R-type ALU");
    endtask

    task automatic run_i_type_ops();
        data_t       a;
        data_t       got;
        logic [15:0] neg_imm;
        logic [15:0] z_imm;
        logic [15:0] up_imm;
        a       = $urandom();
        neg_imm = 16'h8000 | 16'($urandom());  // Negative as a signed offset
        z_imm   = 16'h8000 | 16'($urandom());  // Bit 15 set, sign and zero ext differ
        up_imm  = 16'($urandom());
        debug_write(`MPA_DBG_MR, addr_t'(3), a);
        prog.delete();
        prog.push_back(encode_i(6'h09, 3, 4, neg_imm));    // ADDIU
        prog.push_back(encode_i(6'h0c, 3, 5, z_imm));      // ANDI
        prog.push_back(encode_i(6'h0d, 3, 6, z_imm));      // ORI
        prog.push_back(encode_i(6'h0e, 3, 7, z_imm));      // XORI
        prog.push_back(encode_i(6'h0f, 0, 8, up_imm));     // LUI
        load_program();
        run_cycles(prog.size());
        debug_read(`MPA_DBG_MR, addr_t'(4), got);
        check_word(got, a + {16'hffff, neg_imm}, "ADDIU negative imm");
        debug_read(`MPA_DBG_MR, addr_t'(5), got);
        check_word(got, a & {16'h0000, z_imm}, "ANDI");
        debug_read(`MPA_DBG_MR, addr_t'(6), got);
        check_word(got, a | {16'h0000, z_imm}, "ORI");
        debug_read(`MPA_DBG_MR, addr_t'(7), got);
        check_word(got, a ^ {16'h0000, z_imm}, "XORI");
        debug_read(`MPA_DBG_MR, addr_t'(8), got);
        check_word(got, {up_imm, 16'h0000}, "LUI");
        report_test("I-type ALU");
    endtask

    task automatic exercise_loads();
        data_t w;
        data_t got;
        w = $urandom() | 32'h0000_8080;     // Both sign bits set
        debug_write(`MPA_DBG_DM, addr_t'(32'h40), w);
        debug_write(`MPA_DBG_MR, addr_t'(9), 32'h0000_0050);
        prog.delete();
        prog.push_back(encode_i(6'h20, 9, 11, 16'hfff0)); // LB, 0x50 - 0x10
        prog.push_back(encode_i(6'h24, 9, 12, 16'hfff0)); // LBU
        prog.push_back(encode_i(6'h21, 9, 13, 16'hfff0)); // LH
        prog.push_back(encode_i(6'h25, 9, 14, 16'hfff0)); // LHU
        prog.push_back(encode_i(6'h23, 9, 15, 16'hfff0)); // LW
        load_program();
        run_cycles(prog.size());
        debug_read(`MPA_DBG_MR, addr_t'(11), got);
        check_word(got, {24'hff_ffff, w[7:0]}, "LB");
        debug_read(`MPA_DBG_MR, addr_t'(12), got);
        check_word(got, {24'h00_0000, w[7:0]}, "LBU");
        debug_read(`MPA_DBG_MR, addr_t'(13), got);
        check_word(got, {16'hffff, w[15:0]}, "LH");
        debug_read(`MPA_DBG_MR, addr_t'(14), got);
        check_word(got, {16'h0000, w[15:0]}, "LHU");
        debug_read(`MPA_DBG_MR, addr_t'(15), got);
        check_word(got, w, "LW");
        report_test("loads");
    endtask

    task automatic exercise_stores();
        data_t fill [3];
        data_t v;
        data_t got;
        for (int i = 0; i < 3; i++) begin
            fill[i] = $urandom();
            debug_write(`MPA_DBG_DM, addr_t'(32'h50 + 4 * i), fill[i]);
        end
        v = $urandom();
        debug_write(`MPA_DBG_MR, addr_t'(9), 32'h0000_0050);
        debug_write(`MPA_DBG_MR, addr_t'(20), v);
        prog.delete();
        prog.push_back(encode_i(6'h28, 9, 20, 16'h0000)); // SB
        prog.push_back(encode_i(6'h29, 9, 20, 16'h0004)); // SH
        prog.push_back(encode_i(6'h2b, 9, 20, 16'h0008)); // SW
        load_program();
        run_cycles(prog.size());
        debug_read(`MPA_DBG_DM, addr_t'(32'h50), got);
        check_word(got, {fill[0][31:8], v[7:0]}, "SB low byte only");
        debug_read(`MPA_DBG_DM, addr_t'(32'h54), got);
        check_word(got, {fill[1][31:16], v[15:0]}, "SH low half only");
        debug_read(`MPA_DBG_DM, addr_t'(32'h58), got);
        check_word(got, v, "SW whole word");
        report_test("stores");
    endtask

    task automatic check_unsupported();
        data_t rf_snap [32];
        data_t dm_snap [32];
        data_t got;
        for (int i = 0; i < 32; i++) begin
            debug_read(`MPA_DBG_MR, addr_t'(i), rf_snap[i]);
            debug_read(`MPA_DBG_DM, addr_t'(4 * i), dm_snap[i]);
        end
        prog.delete();
        prog.push_back(encode_r(1, 2, 21, 6'h2a));        // SLT
        prog.push_back(encode_i(6'h04, 1, 1, 16'h0010));  // BEQ, taken if it existed
        load_program();
        run_cycles(prog.size());
        for (int i = 0; i < 32; i++) begin
            debug_read(`MPA_DBG_MR, addr_t'(i), got);
            check_word(got, rf_snap[i], $sformatf("r%0d after SLT/BEQ", i));
            debug_read(`MPA_DBG_DM, addr_t'(4 * i), got);
            check_word(got, dm_snap[i], $sformatf("DM word %0d after SLT/BEQ", i));
        end
        report_test("unsupported codes");
    endtask

    task automatic check_reset();
        data_t got;
        data_t want;
        prog.delete();
        repeat (4) prog.push_back(encode_i(6'h09, 22, 22, 16'h0001));  // r22++
        load_program();
        @(posedge mem_debug_clk_gate);
        mem_debug <= 1'b0;
        repeat (2) @(posedge mem_debug_clk_gate);
        hw_rstn <= 1'b0;    // Mid-run, PC at 8
        repeat (3) @(posedge mem_debug_clk_gate);
        hw_rstn <= 1'b1;    // Still in run mode, restart from the reset PC alone
        repeat (prog.size()) @(posedge mem_debug_clk_gate);
        mem_debug <= 1'b1;
        for (int r = 1; r < 32; r++) begin
            want = (r == 22) ? 32'd4 : 32'd0;  // Only the rerun writes r22
            debug_read(`MPA_DBG_MR, addr_t'(r), got);
            check_word(got, want, $sformatf("r%0d after reset and rerun", r));
        end
        report_test("reset");
    endtask

    initial begin
        void'($urandom(32'hfd73_19ac));
        hw_rstn      = 1'b0;
        mem_debug    = 1'b1;
        debug_func   = '0;
        debug_we     = 1'b0;
        addr         = '0;
        din          = '0;
        err_cnt      = 0;
        test_cnt     = 0;
        err_at_start = 0;
        repeat (8) @(posedge mem_debug_clk_gate);
        hw_rstn <= 1'b1;
        check_back_door();
        run_r_type_ops();
        run_i_type_ops();
        exercise_loads();
        exercise_stores();
        check_unsupported();
        check_reset();
        $display("%0d tests run, %0d checks failed", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
